/* bench/soc_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top_tb;
    import soc_pkg::*;

    localparam int TICK_DIV   = 4;
    localparam int SCAN_DIV   = 3;
    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] GPIO_WORD = 32'hfe54dc10;

    // segments a..g in bits 0..6, standard hex shapes.
    localparam logic [6:0] HEX_SEGS [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    typedef struct {
        logic        is_read;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        logic [31:0] exp;
        int          exp_stall;
        string       name;
    } bus_step_t;

    logic        clk;
    logic        reset_i;
    logic [31:0] dbus_address_i;
    logic [3:0]  dbus_byteenable_i;
    logic        dbus_read_i;
    logic        dbus_write_i;
    logic [31:0] dbus_wrdata_i;
    logic [31:0] dbus_rddata_o;
    logic        dbus_stall_o;
    logic [31:0] gpio_in_i;
    logic [15:0] leds_o;
    logic [7:0]  dpy_com_o;
    logic [7:0]  dpy_seg_o;
    logic        irq_o;

    int        cycles = 0;
    int        seed = 4;
    bus_step_t bus_steps[$];

    soc_top #(.RAM_WORDS(16), .TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) u_soc_top (
        .clk               (clk),
        .reset_i           (reset_i),
        .dbus_address_i    (dbus_address_i),
        .dbus_byteenable_i (dbus_byteenable_i),
        .dbus_read_i       (dbus_read_i),
        .dbus_write_i      (dbus_write_i),
        .dbus_wrdata_i     (dbus_wrdata_i),
        .dbus_rddata_o     (dbus_rddata_o),
        .dbus_stall_o      (dbus_stall_o),
        .gpio_in_i         (gpio_in_i),
        .leds_o            (leds_o),
        .dpy_com_o         (dpy_com_o),
        .dpy_seg_o         (dpy_seg_o),
        .irq_o             (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] map_addr(input logic [3:0] region, input int word);
        logic [11:0] byte_off;
        byte_off = 12'(word * 4);
        return {16'h0000, region, byte_off};
    endfunction

    task automatic add_step(input logic is_read, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data, input logic [31:0] exp,
                            input int exp_stall, input string name);
        bus_step_t s;
        s.is_read   = is_read;
        s.addr      = addr;
        s.be        = be;
        s.data      = data;
        s.exp       = exp;
        s.exp_stall = exp_stall;
        s.name      = name;
        bus_steps.push_back(s);
    endtask

    // one access, held until the stall drops; outputs sampled mid low phase.
    task automatic bus_access(input logic is_read, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int stalls,
                              output int done_cycle);
        @(negedge clk);
        dbus_address_i    = addr;
        dbus_byteenable_i = be;
        dbus_wrdata_i     = wdata;
        dbus_read_i       = is_read;
        dbus_write_i      = !is_read;
        stalls = 0;
        #10;
        while (dbus_stall_o) begin
            stalls++;
            @(negedge clk);
            #10;
        end
        rdata      = dbus_rddata_o;
        done_cycle = cycles;
        @(negedge clk);  // access completed on the edge before.
        dbus_read_i  = 1'b0;
        dbus_write_i = 1'b0;
    endtask

    initial begin
        int          ram_offs [4];
        logic [31:0] words [4];
        logic [31:0] old_word;
        logic [31:0] part_word;
        logic [31:0] in_word;
        logic [31:0] rdata;
        logic [31:0] v;
        logic [31:0] hi;
        logic [7:0]  seen;
        int          stalls;
        int          c0;
        int          c1;
        int          waited;
        int          digit;

        reset_i           = 1'b1;
        dbus_address_i    = '0;
        dbus_byteenable_i = '0;
        dbus_read_i       = 1'b0;
        dbus_write_i      = 1'b0;
        dbus_wrdata_i     = '0;
        gpio_in_i         = '0;
        ram_offs = '{0, 3, 7, 15};
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        #10;
        check_value("reset stall", 0, {31'h0, dbus_stall_o});
        check_value("reset irq", 0, {31'h0, irq_o});
        check_value("reset leds", 0, {16'h0, leds_o});
        check_value("reset digit", 1, {24'h0, dpy_com_o});

        for (int i = 0; i < 4; i++) begin
            words[i] = $random(seed);
            add_step(1'b0, map_addr(REGION_RAM, ram_offs[i]), 4'hf, words[i], '0, 0, "ram write");
        end
        for (int i = 0; i < 4; i++) begin
            add_step(1'b1, map_addr(REGION_RAM, ram_offs[i]), 4'hf, '0, words[i], 1, "ram read");
        end
        old_word  = $random(seed);
        part_word = $random(seed);
        add_step(1'b0, map_addr(REGION_RAM, 5), 4'hf, old_word, '0, 0, "ram full write");
        add_step(1'b0, map_addr(REGION_RAM, 5), 4'b0101, part_word, '0, 0, "ram part write");
        add_step(1'b1, map_addr(REGION_RAM, 5), 4'hf, '0,
                 (old_word & 32'hff00ff00) | (part_word & 32'h00ff00ff), 1, "ram merge");
        add_step(1'b0, map_addr(REGION_GPIO, 0), 4'hf, 32'h76543210, '0, 0, "gpio write");
        add_step(1'b0, map_addr(REGION_GPIO, 0), 4'b1010, 32'hfe00dc00, '0, 0, "gpio part");
        add_step(1'b1, map_addr(REGION_GPIO, 0), 4'hf, '0, GPIO_WORD, 0, "gpio readback");
        add_step(1'b1, 32'h0001_0000, 4'hf, '0, '0, 0, "unmapped high read");
        add_step(1'b1, 32'h0000_3000, 4'hf, '0, '0, 0, "unmapped region read");
        add_step(1'b0, 32'h0001_0000, 4'hf, $random(seed), '0, 0, "unmapped ram alias write");
        add_step(1'b0, 32'h0001_1000, 4'hf, 32'h0, '0, 0, "unmapped gpio alias write");
        add_step(1'b1, map_addr(REGION_RAM, 0), 4'hf, '0, words[0], 1, "ram after unmapped");
        add_step(1'b1, map_addr(REGION_GPIO, 0), 4'hf, '0, GPIO_WORD, 0, "gpio after unmapped");

        foreach (bus_steps[i]) begin
            bus_access(bus_steps[i].is_read, bus_steps[i].addr, bus_steps[i].be,
                       bus_steps[i].data, rdata, stalls, c0);
            check_value({bus_steps[i].name, " stall"}, bus_steps[i].exp_stall, stalls);
            if (bus_steps[i].is_read) begin
                check_value(bus_steps[i].name, bus_steps[i].exp, rdata);
            end
        end
        check_value("leds", {16'h0, GPIO_WORD[15:0]}, {16'h0, leds_o});

        in_word = $random(seed);
        @(negedge clk);
        gpio_in_i = in_word;
        @(negedge clk);  // the access below starts on the second idle edge.
        bus_access(1'b1, map_addr(REGION_GPIO, 1), 4'hf, '0, rdata, stalls, c0);
        check_value("gpio input", in_word, rdata);

        v = $random(seed) & 32'h0000ffff;
        bus_access(1'b0, map_addr(REGION_TICK, 0), 4'hf, v, rdata, stalls, c0);
        repeat (9) @(negedge clk);
        bus_access(1'b1, map_addr(REGION_TICK, 0), 4'hf, '0, rdata, stalls, c1);
        hi = v + (c1 - c0) / TICK_DIV + 1;
        check_value("tick count window", 1, {31'h0, (rdata >= v) && (rdata <= hi)});

        bus_access(1'b0, map_addr(REGION_TICK, 1), 4'hf, 32'd3, rdata, stalls, c0);
        bus_access(1'b0, map_addr(REGION_TICK, 0), 4'hf, 32'd0, rdata, stalls, c0);
        check_value("irq before match", 0, {31'h0, irq_o});
        waited = 0;
        while (!irq_o && waited < 4 * TICK_DIV + 4) begin
            @(negedge clk);
            waited++;
        end
        check_value("irq rise", 1, {31'h0, irq_o});
        repeat (6) begin
            @(negedge clk);
            check_value("irq held", 1, {31'h0, irq_o});
        end
        bus_access(1'b1, map_addr(REGION_TICK, 2), 4'hf, '0, rdata, stalls, c0);
        check_value("irq status", 1, rdata);
        bus_access(1'b0, map_addr(REGION_TICK, 2), 4'hf, 32'd1, rdata, stalls, c0);
        check_value("irq after ack", 0, {31'h0, irq_o});

        seen = '0;
        repeat (8 * SCAN_DIV + 8) begin
            @(negedge clk);
            check_value("dpy com one-hot", 1, 32'($onehot(dpy_com_o)));
            digit = 0;
            for (int d = 0; d < 8; d++) begin
                if (dpy_com_o[d]) digit = d;
            end
            seen[digit] = 1'b1;
            check_value($sformatf("dpy seg digit %0d", digit),
                        {25'h0, HEX_SEGS[GPIO_WORD[digit*4 +: 4]]}, {24'h0, dpy_seg_o});
        end
        check_value("digits seen", 32'hff, {24'h0, seen});

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator; exit status is pass or fail.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module soc_top_tb \
    -f sources.f \
    -o soc_top_tb_sim

./obj_dir/soc_top_tb_sim

/* sources.f */
src/soc_pkg.sv
src/dbus_decode.sv
src/data_ram.sv
src/gpio_regs.sv
src/tick_timer.sv
src/seg_scan.sv
src/soc_top.sv
bench/soc_top_tb.sv

/* src/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  wire                            clk,
    input  wire                            reset_i,
    input  wire                            rd_i,
    input  wire                            wr_i,
    input  wire  [soc_pkg::RAM_OFF_W-1:0]  offset_i,
    input  wire  [soc_pkg::BE_W-1:0]       be_i,
    input  wire  [soc_pkg::DATA_W-1:0]     wrdata_i,
    output logic [soc_pkg::DATA_W-1:0]     rddata_o,
    output logic                           stall_o
);
    import soc_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [DATA_W-1:0] rddata_q;
    logic [IDX_W-1:0]  idx;
    logic              rd_pend_q;

    assign idx = offset_i[IDX_W-1:0];

    // per-lane write.
    always_ff @(posedge clk) begin
        if (wr_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be_i[b]) begin
                    mem[idx][b*8 +: 8] <= wrdata_i[b*8 +: 8];
                end
            end
        end
    end

    // first cycle of a read fetches the word, second one returns it.
    always_ff @(posedge clk) begin
        if (rd_i && !rd_pend_q) begin
            rddata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_i && !rd_pend_q;
        end
    end

    assign stall_o  = rd_i && !rd_pend_q;
    assign rddata_o = rddata_q;

endmodule

`default_nettype wire

/* src/dbus_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module dbus_decode (
    input  wire                            clk,
    input  wire                            reset_i,
    input  wire  [soc_pkg::ADDR_W-1:0]     dbus_address_i,
    input  wire  [soc_pkg::BE_W-1:0]       dbus_byteenable_i,
    input  wire                            dbus_read_i,
    input  wire                            dbus_write_i,
    input  wire  [soc_pkg::DATA_W-1:0]     dbus_wrdata_i,
    output logic [soc_pkg::DATA_W-1:0]     dbus_rddata_o,
    output logic                           dbus_stall_o,
    output logic                           ram_rd_o,
    output logic                           ram_wr_o,
    output logic                           gpio_rd_o,
    output logic                           gpio_wr_o,
    output logic                           tick_rd_o,
    output logic                           tick_wr_o,
    output logic [soc_pkg::RAM_OFF_W-1:0]  slv_offset_o,
    output logic [soc_pkg::BE_W-1:0]       slv_be_o,
    output logic [soc_pkg::DATA_W-1:0]     slv_wrdata_o,
    input  wire  [soc_pkg::DATA_W-1:0]     ram_rddata_i,
    input  wire                            ram_stall_i,
    input  wire  [soc_pkg::DATA_W-1:0]     gpio_rddata_i,
    input  wire  [soc_pkg::DATA_W-1:0]     tick_rddata_i
);
    import soc_pkg::*;

    logic       hi_zero;
    logic [3:0] region;
    logic       sel_ram;
    logic       sel_gpio;
    logic       sel_tick;
    logic       ram_rd_pend_q;

    assign hi_zero  = (dbus_address_i[ADDR_W-1:16] == '0);
    assign region   = dbus_address_i[15:12];
    assign sel_ram  = hi_zero && (region == REGION_RAM);
    assign sel_gpio = hi_zero && (region == REGION_GPIO);
    assign sel_tick = hi_zero && (region == REGION_TICK);

    // strobes reach one slave only and unmapped ones go nowhere.
    assign ram_rd_o  = dbus_read_i  && sel_ram;
    assign ram_wr_o  = dbus_write_i && sel_ram;
    assign gpio_rd_o = dbus_read_i  && sel_gpio;
    assign gpio_wr_o = dbus_write_i && sel_gpio;
    assign tick_rd_o = dbus_read_i  && sel_tick;
    assign tick_wr_o = dbus_write_i && sel_tick;

    assign slv_offset_o = dbus_address_i[RAM_OFF_W+1:2];
    assign slv_be_o     = dbus_byteenable_i;
    assign slv_wrdata_o = dbus_wrdata_i;

    // remember a stalled ram read so the mux holds on ram for its data.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ram_rd_pend_q <= 1'b0;
        end else begin
            ram_rd_pend_q <= ram_rd_o && ram_stall_i;
        end
    end

    assign dbus_stall_o = ram_rd_o && ram_stall_i;

    always_comb begin
        if (sel_ram || ram_rd_pend_q) begin
            dbus_rddata_o = ram_rddata_i;
        end else if (sel_gpio) begin
            dbus_rddata_o = gpio_rddata_i;
        end else if (sel_tick) begin
            dbus_rddata_o = tick_rddata_i;
        end else begin
            dbus_rddata_o = '0;  // unmapped.
        end
    end

endmodule

`default_nettype wire

/* src/gpio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
    input  wire                             clk,
    input  wire                             reset_i,
    input  wire                             rd_i,
    input  wire                             wr_i,
    input  wire  [soc_pkg::REG_ADDR_W-1:0]  offset_i,
    input  wire  [soc_pkg::BE_W-1:0]        be_i,
    input  wire  [soc_pkg::DATA_W-1:0]      wrdata_i,
    output logic [soc_pkg::DATA_W-1:0]      rddata_o,
    input  wire  [soc_pkg::DATA_W-1:0]      gpio_in_i,
    output logic [soc_pkg::DATA_W-1:0]      gpio_out_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0] out_q;
    logic [DATA_W-1:0] in_meta_q;
    logic [DATA_W-1:0] in_sync_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (wr_i && offset_i == GPIO_OUT_REG) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be_i[b]) begin
                    out_q[b*8 +: 8] <= wrdata_i[b*8 +: 8];
                end
            end
        end
    end

    // two-stage synchronizer on the input pins.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        rddata_o = '0;
        if (rd_i) begin
            case (offset_i)
                GPIO_OUT_REG: rddata_o = out_q;
                GPIO_IN_REG:  rddata_o = in_sync_q;
                default:      rddata_o = '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;

endmodule

`default_nettype wire

/* src/seg_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module seg_scan #(
    parameter int SCAN_DIV = 1000
) (
    input  wire         clk,
    input  wire         reset_i,
    input  wire  [31:0] value_i,
    output logic [7:0]  com_o,
    output logic [7:0]  seg_o
);
    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_q;
    logic [2:0]       digit_q;
    logic [3:0]       nibble;

    // segments a..g in bits 0..6.
    function automatic logic [6:0] hex_shape(input logic [3:0] n);
        case (n)
            4'h0: hex_shape = 7'h3f;
            4'h1: hex_shape = 7'h06;
            4'h2: hex_shape = 7'h5b;
            4'h3: hex_shape = 7'h4f;
            4'h4: hex_shape = 7'h66;
            4'h5: hex_shape = 7'h6d;
            4'h6: hex_shape = 7'h7d;
            4'h7: hex_shape = 7'h07;
            4'h8: hex_shape = 7'h7f;
            4'h9: hex_shape = 7'h6f;
            4'ha: hex_shape = 7'h77;
            4'hb: hex_shape = 7'h7c;
            4'hc: hex_shape = 7'h39;
            4'hd: hex_shape = 7'h5e;
            4'he: hex_shape = 7'h79;
            default: hex_shape = 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q   <= '0;
            digit_q <= '0;
        end else if (div_q == DIV_W'(SCAN_DIV - 1)) begin
            div_q   <= '0;
            digit_q <= digit_q + 1'b1;  // wraps 7 to 0.
        end else begin
            div_q   <= div_q + 1'b1;
        end
    end

    assign nibble = value_i[digit_q*4 +: 4];
    assign com_o  = 8'b1 << digit_q;
    assign seg_o  = {1'b0, hex_shape(nibble)};  // decimal point off.

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus widths.
    parameter int DATA_W = 32;
    parameter int ADDR_W = 32;
    parameter int BE_W   = DATA_W / 8;

    // word offset inside a peripheral region, address bits 9:2.
    parameter int REG_ADDR_W = 8;

    // word offset inside the ram region, address bits 11:2.
    parameter int RAM_OFF_W = 10;

    // region code sits in address bits 15:12.
    parameter logic [3:0] REGION_RAM  = 4'd0;
    parameter logic [3:0] REGION_GPIO = 4'd1;
    parameter logic [3:0] REGION_TICK = 4'd2;

    // gpio word offsets.
    parameter logic [REG_ADDR_W-1:0] GPIO_OUT_REG = 8'd0;
    parameter logic [REG_ADDR_W-1:0] GPIO_IN_REG  = 8'd1;

    // timer word offsets.
    parameter logic [REG_ADDR_W-1:0] TICK_COUNT_REG = 8'd0;
    parameter logic [REG_ADDR_W-1:0] TICK_CMP_REG   = 8'd1;
    parameter logic [REG_ADDR_W-1:0] TICK_ACK_REG   = 8'd2;

endpackage

`default_nettype wire

/* src/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
    parameter int RAM_WORDS = 1024,
    parameter int TICK_DIV  = 50,
    parameter int SCAN_DIV  = 1000
) (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire  [soc_pkg::ADDR_W-1:0]  dbus_address_i,
    input  wire  [soc_pkg::BE_W-1:0]    dbus_byteenable_i,
    input  wire                         dbus_read_i,
    input  wire                         dbus_write_i,
    input  wire  [soc_pkg::DATA_W-1:0]  dbus_wrdata_i,
    output logic [soc_pkg::DATA_W-1:0]  dbus_rddata_o,
    output logic                        dbus_stall_o,
    input  wire  [soc_pkg::DATA_W-1:0]  gpio_in_i,
    output logic [15:0]                 leds_o,
    output logic [7:0]                  dpy_com_o,
    output logic [7:0]                  dpy_seg_o,
    output logic                        irq_o
);
    import soc_pkg::*;

    logic                 ram_rd, ram_wr, ram_stall;
    logic                 gpio_rd, gpio_wr;
    logic                 tick_rd, tick_wr;
    logic [RAM_OFF_W-1:0] slv_offset;
    logic [BE_W-1:0]      slv_be;
    logic [DATA_W-1:0]    slv_wrdata;
    logic [DATA_W-1:0]    ram_rddata, gpio_rddata, tick_rddata;
    logic [DATA_W-1:0]    gpio_out;

    dbus_decode u_dbus_decode (
        .clk               (clk),
        .reset_i           (reset_i),
        .dbus_address_i    (dbus_address_i),
        .dbus_byteenable_i (dbus_byteenable_i),
        .dbus_read_i       (dbus_read_i),
        .dbus_write_i      (dbus_write_i),
        .dbus_wrdata_i     (dbus_wrdata_i),
        .dbus_rddata_o     (dbus_rddata_o),
        .dbus_stall_o      (dbus_stall_o),
        .ram_rd_o          (ram_rd),
        .ram_wr_o          (ram_wr),
        .gpio_rd_o         (gpio_rd),
        .gpio_wr_o         (gpio_wr),
        .tick_rd_o         (tick_rd),
        .tick_wr_o         (tick_wr),
        .slv_offset_o      (slv_offset),
        .slv_be_o          (slv_be),
        .slv_wrdata_o      (slv_wrdata),
        .ram_rddata_i      (ram_rddata),
        .ram_stall_i       (ram_stall),
        .gpio_rddata_i     (gpio_rddata),
        .tick_rddata_i     (tick_rddata)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
        .clk      (clk),
        .reset_i  (reset_i),
        .rd_i     (ram_rd),
        .wr_i     (ram_wr),
        .offset_i (slv_offset),
        .be_i     (slv_be),
        .wrdata_i (slv_wrdata),
        .rddata_o (ram_rddata),
        .stall_o  (ram_stall)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_i       (gpio_rd),
        .wr_i       (gpio_wr),
        .offset_i   (slv_offset[REG_ADDR_W-1:0]),
        .be_i       (slv_be),
        .wrdata_i   (slv_wrdata),
        .rddata_o   (gpio_rddata),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out)
    );

    tick_timer #(.TICK_DIV(TICK_DIV)) u_tick_timer (
        .clk      (clk),
        .reset_i  (reset_i),
        .rd_i     (tick_rd),
        .wr_i     (tick_wr),
        .offset_i (slv_offset[REG_ADDR_W-1:0]),
        .wrdata_i (slv_wrdata),
        .rddata_o (tick_rddata),
        .irq_o    (irq_o)
    );

    seg_scan #(.SCAN_DIV(SCAN_DIV)) u_seg_scan (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (gpio_out),
        .com_o   (dpy_com_o),
        .seg_o   (dpy_seg_o)
    );

    assign leds_o = gpio_out[15:0];

endmodule

`default_nettype wire

/* src/tick_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_timer #(
    parameter int TICK_DIV = 50
) (
    input  wire                             clk,
    input  wire                             reset_i,
    input  wire                             rd_i,
    input  wire                             wr_i,
    input  wire  [soc_pkg::REG_ADDR_W-1:0]  offset_i,
    input  wire  [soc_pkg::DATA_W-1:0]      wrdata_i,
    output logic [soc_pkg::DATA_W-1:0]      rddata_o,
    output logic                            irq_o
);
    import soc_pkg::*;

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]  pre_q;
    logic              tick;
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] count_nxt;
    logic [DATA_W-1:0] cmp_q;
    logic              irq_q;

    assign tick      = (pre_q == PRE_W'(TICK_DIV - 1));
    assign count_nxt = count_q + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pre_q   <= '0;
            count_q <= '0;
            cmp_q   <= '1;
        end else begin
            if (wr_i && offset_i == TICK_COUNT_REG) begin
                count_q <= wrdata_i;
                pre_q   <= '0;  // restart the prescaler on load.
            end else if (tick) begin
                count_q <= count_nxt;
                pre_q   <= '0;
            end else begin
                pre_q   <= pre_q + 1'b1;
            end
            if (wr_i && offset_i == TICK_CMP_REG) begin
                cmp_q <= wrdata_i;
            end
        end
    end

    // sticky until acknowledged, ack wins over a new match.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_q <= 1'b0;
        end else if (wr_i && offset_i == TICK_ACK_REG) begin
            irq_q <= 1'b0;
        end else if (tick && !(wr_i && offset_i == TICK_COUNT_REG) && count_nxt == cmp_q) begin
            irq_q <= 1'b1;
        end
    end

    always_comb begin
        rddata_o = '0;
        if (rd_i) begin
            case (offset_i)
                TICK_COUNT_REG: rddata_o = count_q;
                TICK_CMP_REG:   rddata_o = cmp_q;
                TICK_ACK_REG:   rddata_o = {{(DATA_W-1){1'b0}}, irq_q};
                default:        rddata_o = '0;
            endcase
        end
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire
